/* common/ccl_consts.svh */
`ifndef CCL_CONSTS_SVH
`define CCL_CONSTS_SVH

// mask geometry for this build
`define FRAME_WIDTH 32
`define FRAME_HEIGHT 24

// coordinate widths as seen on the camera side
`define X_BITS 11
`define Y_BITS 10

// covers FRAME_WIDTH * FRAME_HEIGHT
`define ADDR_BITS 10

// address to pixel at the frame buffers
`define READ_LATENCY 2

`endif

/* common/ccl_pkg.sv */
`default_nettype none

`include "ccl_consts.svh"

package ccl_pkg;

  typedef struct packed {
    logic [`Y_BITS-1:0] y;
    logic [`X_BITS-1:0] x;
  } coord_t;

  typedef logic [`ADDR_BITS-1:0] pix_addr_t;  // x + y * width

  // side the trace entered the current pixel from
  typedef enum logic [1:0] {
    UP,
    RIGHT,
    DOWN,
    LEFT
  } dir_e;

  typedef enum logic [1:0] {
    IDLE,
    SEARCH,
    TRACE,
    DONE
  } trace_state_e;

  // slots numbered clockwise, so from * 2 + 1 is the first slot to check
  typedef enum logic [2:0] {
    N_UPLEFT,
    N_UP,
    N_UPRIGHT,
    N_RIGHT,
    N_DOWNRIGHT,
    N_DOWN,
    N_DOWNLEFT,
    N_LEFT
  } nbr_e;

  typedef logic [7:0] nbr_pix_t;  // indexed by nbr_e

  typedef struct packed {
    pix_addr_t [7:0] nbr;  // indexed by nbr_e
    pix_addr_t search;
  } rd_req_t;

  typedef struct packed {
    logic found;
    coord_t start;
    logic [`ADDR_BITS-1:0] perimeter;
  } trace_result_t;

endpackage

`default_nettype wire

/* verilog/raster_search.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ccl_consts.svh"

module raster_search (
  input wire clk_in,
  input wire rst_in,
  input wire search_run,
  input wire rd_search_pix,
  output ccl_pkg::pix_addr_t search_addr,
  output logic search_hit,
  output ccl_pkg::coord_t hit_pos,
  output logic search_empty
);
  import ccl_pkg::*;

  coord_t scan_pos;
  logic scan_end;  // last pixel already issued
  logic issue;
  coord_t tag_pos [`READ_LATENCY];
  logic [`READ_LATENCY-1:0] tag_vld;
  logic tag_last;

  assign issue = search_run && !scan_end;
  assign search_addr = pix_addr_t'(scan_pos.y * `FRAME_WIDTH + scan_pos.x);

  always_ff @(posedge clk_in) begin
    if (rst_in || !search_run) begin
      scan_pos <= '0;  // next run starts at the origin
      scan_end <= 1'b0;
    end else if (!scan_end) begin
      if (scan_pos.x == `X_BITS'(`FRAME_WIDTH - 1)) begin
        scan_pos.x <= '0;
        if (scan_pos.y == `Y_BITS'(`FRAME_HEIGHT - 1)) begin
          scan_end <= 1'b1;
        end else begin
          scan_pos.y <= scan_pos.y + 1'b1;
        end
      end else begin
        scan_pos.x <= scan_pos.x + 1'b1;
      end
    end
  end

  // tags follow their reads through the buffer latency
  always_ff @(posedge clk_in) begin
    if (rst_in || !search_run) begin
      tag_vld <= '0;  // drop reads still in flight
    end else begin
      tag_vld[0] <= issue;
      for (int i = 1; i < `READ_LATENCY; i++) begin
        tag_vld[i] <= tag_vld[i-1];
      end
    end
  end

  always_ff @(posedge clk_in) begin
    tag_pos[0] <= scan_pos;
    for (int i = 1; i < `READ_LATENCY; i++) begin
      tag_pos[i] <= tag_pos[i-1];
    end
  end

  assign hit_pos = tag_pos[`READ_LATENCY-1];
  assign tag_last = (hit_pos.x == `X_BITS'(`FRAME_WIDTH - 1)) &&
                    (hit_pos.y == `Y_BITS'(`FRAME_HEIGHT - 1));
  assign search_hit = search_run && tag_vld[`READ_LATENCY-1] && rd_search_pix;
  assign search_empty = search_run && tag_vld[`READ_LATENCY-1] && !rd_search_pix && tag_last;

  // one outcome per search run
  a_one_outcome: assert property (@(posedge clk_in) disable iff (rst_in)
    search_hit || search_empty |=> !search_hit && !search_empty);

endmodule

`default_nettype wire

/* verilog/trace_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ccl_consts.svh"

module trace_ctrl (
  input wire clk_in,
  input wire rst_in,
  input wire start_valid,
  output logic start_ready,
  output logic search_run,
  input wire search_hit,
  input ccl_pkg::coord_t hit_pos,
  input wire search_empty,
  input ccl_pkg::coord_t next_pos,
  input ccl_pkg::dir_e next_from,
  input wire isolated,
  output ccl_pkg::coord_t trace_pos,
  output ccl_pkg::dir_e from,
  output ccl_pkg::trace_result_t result,
  output logic result_valid,
  input wire result_ready
);
  import ccl_pkg::*;

  trace_state_e state;
  coord_t start_pos;
  logic [$clog2(`READ_LATENCY + 1)-1:0] wait_cnt;
  logic [`ADDR_BITS-1:0] perim;
  logic step_now;  // pixels for the held addresses are back

  assign start_ready = (state == IDLE);
  assign search_run = (state == SEARCH);
  assign result_valid = (state == DONE);
  assign step_now = (wait_cnt == ($bits(wait_cnt))'(`READ_LATENCY));

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= IDLE;
      wait_cnt <= '0;
      perim <= '0;
      from <= UP;
      result <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start_valid) state <= SEARCH;
        end
        SEARCH: begin
          if (search_hit) begin
            state <= TRACE;
            start_pos <= hit_pos;
            trace_pos <= hit_pos;
            from <= UP;  // nothing above the first raster hit
            wait_cnt <= '0;
            perim <= '0;
          end else if (search_empty) begin
            state <= DONE;
            result <= '0;  // empty mask
          end
        end
        TRACE: begin
          if (!step_now) begin
            wait_cnt <= wait_cnt + 1'b1;
          end else if (isolated) begin
            state <= DONE;
            result <= '{found: 1'b1, start: start_pos, perimeter: '0};
          end else begin
            wait_cnt <= '0;
            trace_pos <= next_pos;
            from <= next_from;
            perim <= perim + 1'b1;
            if (next_pos == start_pos) begin  // back at start, loop closed
              state <= DONE;
              result <= '{found: 1'b1, start: start_pos, perimeter: perim + 1'b1};
            end
          end
        end
        DONE: begin
          if (result_ready) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  a_result_hold: assert property (@(posedge clk_in) disable iff (rst_in)
    result_valid && !result_ready |=> result_valid && $stable(result));

  a_pos_in_frame: assert property (@(posedge clk_in) disable iff (rst_in)
    state == TRACE |-> trace_pos.x < `FRAME_WIDTH && trace_pos.y < `FRAME_HEIGHT);

endmodule

`default_nettype wire

/* trace/neighbor_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ccl_consts.svh"

module neighbor_fetch (
  input ccl_pkg::coord_t trace_pos,
  input ccl_pkg::nbr_pix_t rd_pix,
  output ccl_pkg::pix_addr_t [7:0] nbr_addr,
  output ccl_pkg::nbr_pix_t nbr_pix
);
  import ccl_pkg::*;

  logic has_l, has_r, has_u, has_d;
  logic [7:0] in_frame;
  pix_addr_t col_l, col_c, col_r;
  pix_addr_t row_u, row_c, row_d;
  pix_addr_t [7:0] raw_addr;

  assign has_l = (trace_pos.x != '0);
  assign has_r = (trace_pos.x != `X_BITS'(`FRAME_WIDTH - 1));
  assign has_u = (trace_pos.y != '0);
  assign has_d = (trace_pos.y != `Y_BITS'(`FRAME_HEIGHT - 1));

  // wrapped values at the border are masked below
  assign col_l = pix_addr_t'(trace_pos.x - 1'b1);
  assign col_c = pix_addr_t'(trace_pos.x);
  assign col_r = pix_addr_t'(trace_pos.x + 1'b1);
  assign row_u = pix_addr_t'((trace_pos.y - 1'b1) * `FRAME_WIDTH);
  assign row_c = pix_addr_t'(trace_pos.y * `FRAME_WIDTH);
  assign row_d = pix_addr_t'((trace_pos.y + 1'b1) * `FRAME_WIDTH);

  always_comb begin
    raw_addr[N_UPLEFT] = row_u + col_l;
    raw_addr[N_UP] = row_u + col_c;
    raw_addr[N_UPRIGHT] = row_u + col_r;
    raw_addr[N_RIGHT] = row_c + col_r;
    raw_addr[N_DOWNRIGHT] = row_d + col_r;
    raw_addr[N_DOWN] = row_d + col_c;
    raw_addr[N_DOWNLEFT] = row_d + col_l;
    raw_addr[N_LEFT] = row_c + col_l;

    in_frame[N_UPLEFT] = has_u && has_l;
    in_frame[N_UP] = has_u;
    in_frame[N_UPRIGHT] = has_u && has_r;
    in_frame[N_RIGHT] = has_r;
    in_frame[N_DOWNRIGHT] = has_d && has_r;
    in_frame[N_DOWN] = has_d;
    in_frame[N_DOWNLEFT] = has_d && has_l;
    in_frame[N_LEFT] = has_l;
  end

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      nbr_addr[i] = in_frame[i] ? raw_addr[i] : '0;
      nbr_pix[i] = in_frame[i] && rd_pix[i];  // never step off the frame
    end
  end

endmodule

`default_nettype wire

/* trace/moore_step.sv */
`timescale 1ns/100ps
`default_nettype none

module moore_step (
  input ccl_pkg::coord_t trace_pos,
  input ccl_pkg::dir_e from,
  input ccl_pkg::nbr_pix_t nbr_pix,
  output ccl_pkg::coord_t next_pos,
  output ccl_pkg::dir_e next_from,
  output logic isolated
);
  import ccl_pkg::*;

  logic [2:0] first_slot;
  logic [2:0] slot;
  logic picked;
  nbr_e pick;

  assign first_slot = {from, 1'b1};  // up, right, down or left slot
  assign isolated = (nbr_pix == '0);

  // clockwise walk from the entry side, first set slot wins
  always_comb begin
    picked = 1'b0;
    pick = N_UP;
    slot = first_slot;
    for (int k = 0; k < 8; k++) begin
      slot = first_slot + 3'(k);
      if (!picked && nbr_pix[slot]) begin
        picked = 1'b1;
        pick = nbr_e'(slot);
      end
    end
  end

  always_comb begin
    next_pos = trace_pos;
    next_from = from;
    case (pick)
      N_UP: begin
        next_pos.y = trace_pos.y - 1'b1;
        next_from = LEFT;
      end
      N_UPRIGHT: begin
        next_pos.x = trace_pos.x + 1'b1;
        next_pos.y = trace_pos.y - 1'b1;
        next_from = LEFT;
      end
      N_RIGHT: begin
        next_pos.x = trace_pos.x + 1'b1;
        next_from = UP;
      end
      N_DOWNRIGHT: begin
        next_pos.x = trace_pos.x + 1'b1;
        next_pos.y = trace_pos.y + 1'b1;
        next_from = UP;
      end
      N_DOWN: begin
        next_pos.y = trace_pos.y + 1'b1;
        next_from = RIGHT;
      end
      N_DOWNLEFT: begin
        next_pos.x = trace_pos.x - 1'b1;
        next_pos.y = trace_pos.y + 1'b1;
        next_from = RIGHT;
      end
      N_LEFT: begin
        next_pos.x = trace_pos.x - 1'b1;
        next_from = DOWN;
      end
      default: begin  // up-left
        next_pos.x = trace_pos.x - 1'b1;
        next_pos.y = trace_pos.y - 1'b1;
        next_from = DOWN;
      end
    endcase
  end

endmodule

`default_nettype wire

/* verilog/contour_tracer.sv */
`timescale 1ns/100ps
`default_nettype none

module contour_tracer (
  input wire clk_in,
  input wire rst_in,
  input wire start_valid,
  output logic start_ready,
  output ccl_pkg::rd_req_t rd_req,
  input ccl_pkg::nbr_pix_t rd_pix,
  input wire rd_search_pix,
  output ccl_pkg::trace_result_t result,
  output logic result_valid,
  input wire result_ready
);
  import ccl_pkg::*;

  logic search_run;
  logic search_hit;
  logic search_empty;
  coord_t hit_pos;
  pix_addr_t search_addr;

  coord_t trace_pos;
  coord_t next_pos;
  dir_e from;
  dir_e next_from;
  logic isolated;

  pix_addr_t [7:0] nbr_addr;
  nbr_pix_t nbr_pix;  // out-of-frame slots already cleared

  raster_search u_search (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .search_run(search_run),
    .rd_search_pix(rd_search_pix),
    .search_addr(search_addr),
    .search_hit(search_hit),
    .hit_pos(hit_pos),
    .search_empty(search_empty)
  );

  trace_ctrl u_ctrl (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .start_valid(start_valid),
    .start_ready(start_ready),
    .search_run(search_run),
    .search_hit(search_hit),
    .hit_pos(hit_pos),
    .search_empty(search_empty),
    .next_pos(next_pos),
    .next_from(next_from),
    .isolated(isolated),
    .trace_pos(trace_pos),
    .from(from),
    .result(result),
    .result_valid(result_valid),
    .result_ready(result_ready)
  );

  neighbor_fetch u_fetch (
    .trace_pos(trace_pos),
    .rd_pix(rd_pix),
    .nbr_addr(nbr_addr),
    .nbr_pix(nbr_pix)
  );

  moore_step u_step (
    .trace_pos(trace_pos),
    .from(from),
    .nbr_pix(nbr_pix),
    .next_pos(next_pos),
    .next_from(next_from),
    .isolated(isolated)
  );

  assign rd_req.search = search_addr;
  assign rd_req.nbr = nbr_addr;

endmodule

`default_nettype wire

/* tests/trace_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module trace_checker (
  input wire clk_in,
  input wire rst_in,
  input wire start_valid,
  input wire start_ready,
  input ccl_pkg::trace_result_t result,
  input wire result_valid,
  input wire result_ready,
  input ccl_pkg::trace_result_t exp_result,
  input wire [31:0] cycle_limit,
  output int error_count,
  output int result_count,
  output logic timed_out
);
  import ccl_pkg::*;

  int cycle_cnt;
  logic pending;  // start taken and result not yet accepted
  logic holding;  // result offered but not taken
  logic reset_seen;
  trace_result_t held;

  initial begin
    error_count = 0;
    result_count = 0;
    timed_out = 1'b0;
    cycle_cnt = 0;
    pending = 1'b0;
    holding = 1'b0;
    reset_seen = 1'b0;
    held = '0;
  end

  task check_field(input string name, input logic [31:0] got, input logic [31:0] expected);
    if (got !== expected) begin
      $display("mismatch at %0d ns: %s got %0d expected %0d", $time, name, got, expected);
      error_count++;
    end
  endtask

  task check_result(input string tag, input trace_result_t expected);
    check_field({"result.found", tag}, 32'(result.found), 32'(expected.found));
    check_field({"result.start.x", tag}, 32'(result.start.x), 32'(expected.start.x));
    check_field({"result.start.y", tag}, 32'(result.start.y), 32'(expected.start.y));
    check_field({"result.perimeter", tag}, 32'(result.perimeter), 32'(expected.perimeter));
  endtask

  always @(posedge clk_in) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit && !timed_out) begin
      $display("timeout: run still going after %0d cycles", cycle_cnt);
      error_count++;
      timed_out = 1'b1;
    end
    if (rst_in) begin
      pending = 1'b0;
      holding = 1'b0;
      reset_seen = 1'b1;
    end else begin
      if (reset_seen) begin  // first cycle out of reset
        check_field("start_ready", 32'(start_ready), 32'd1);
        check_field("result_valid", 32'(result_valid), 32'd0);
        reset_seen = 1'b0;
      end
      if (holding) begin
        if (!result_valid) begin
          $display("result_valid dropped at %0d ns before result_ready was seen", $time);
          error_count++;
        end else begin
          check_result(" (held)", held);
        end
      end
      if (pending) check_field("start_ready", 32'(start_ready), 32'd0);
      if (start_valid && start_ready) begin
        pending = 1'b1;
      end
      if (result_valid && !pending) begin
        $display("result offered at %0d ns without a start before it", $time);
        error_count++;
      end
      if (result_valid && result_ready) begin
        check_result("", exp_result);
        pending = 1'b0;
        result_count++;
      end
      holding = result_valid && !result_ready;
      held = result;
    end
  end

endmodule

`default_nettype wire

/* tests/contour_tracer_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ccl_consts.svh"

module contour_tracer_tb;
  import ccl_pkg::*;

  localparam int NUM_TESTS = 16;
  localparam int PIXELS = `FRAME_WIDTH * `FRAME_HEIGHT;
  localparam int LAT = `READ_LATENCY;

  typedef struct packed {
    logic [7:0] x;
    logic [7:0] y;
    logic [7:0] w;  // zero means unused
    logic [7:0] h;
  } rect_t;

  typedef struct packed {
    rect_t a;
    rect_t b;
    trace_result_t exp;
  } test_row_t;

  logic clk_in;
  logic rst_in;
  logic start_valid;
  logic start_ready;
  rd_req_t rd_req;
  nbr_pix_t rd_pix;
  logic rd_search_pix;
  trace_result_t result;
  logic result_valid;
  logic result_ready;

  trace_result_t exp_result;
  logic [31:0] cycle_limit;
  int error_count;
  int result_count;
  logic timed_out;

  logic mask [PIXELS];
  nbr_pix_t pix_pipe [LAT];
  logic search_pipe [LAT];
  test_row_t rows [NUM_TESTS];
  int unsigned stall_len [NUM_TESTS];

  contour_tracer contour_tracer_inst (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .start_valid(start_valid),
    .start_ready(start_ready),
    .rd_req(rd_req),
    .rd_pix(rd_pix),
    .rd_search_pix(rd_search_pix),
    .result(result),
    .result_valid(result_valid),
    .result_ready(result_ready)
  );

  trace_checker u_checker (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .start_valid(start_valid),
    .start_ready(start_ready),
    .result(result),
    .result_valid(result_valid),
    .result_ready(result_ready),
    .exp_result(exp_result),
    .cycle_limit(cycle_limit),
    .error_count(error_count),
    .result_count(result_count),
    .timed_out(timed_out)
  );

  always #2 clk_in = ~clk_in;

  // frame buffer model, addresses taken at the rising edge
  always @(posedge clk_in) begin
    nbr_pix_t fetched;
    for (int i = 0; i < 8; i++) begin
      fetched[i] = mask[rd_req.nbr[i]];
    end
    pix_pipe[0] <= fetched;
    search_pipe[0] <= mask[rd_req.search];
    for (int i = 1; i < LAT; i++) begin
      pix_pipe[i] <= pix_pipe[i-1];
      search_pipe[i] <= search_pipe[i-1];
    end
  end

  always @(negedge clk_in) begin
    rd_pix <= pix_pipe[LAT-1];  // valid well before the sampling edge
    rd_search_pix <= search_pipe[LAT-1];
  end

  function automatic rect_t make_rect(input int x, input int y, input int w, input int h);
    make_rect = '{x: 8'(x), y: 8'(y), w: 8'(w), h: 8'(h)};
  endfunction

  function automatic trace_result_t make_expect(input int sx, input int sy, input int perim);
    trace_result_t r;
    r.found = 1'b1;
    r.start.x = `X_BITS'(sx);
    r.start.y = `Y_BITS'(sy);
    r.perimeter = `ADDR_BITS'(perim);
    return r;
  endfunction

  // start is the raster-first top-left corner, perimeter 2(w-1)+2(h-1)
  task fill_table;
    rect_t none;
    none = '0;
    rows[0] = '{a: none, b: none, exp: '0};  // empty mask
    rows[1] = '{a: make_rect(5, 4, 6, 3), b: none, exp: make_expect(5, 4, 14)};
    rows[2] = '{a: make_rect(0, 0, 4, 3), b: none, exp: make_expect(0, 0, 10)};
    rows[3] = '{a: make_rect(28, 21, 4, 3), b: none, exp: make_expect(28, 21, 10)};
    rows[4] = '{a: make_rect(29, 0, 3, 5), b: none, exp: make_expect(29, 0, 12)};
    rows[5] = '{a: make_rect(0, 20, 6, 4), b: none, exp: make_expect(0, 20, 16)};
    rows[6] = '{a: make_rect(0, 10, 32, 2), b: none, exp: make_expect(0, 10, 64)};
    rows[7] = '{a: make_rect(17, 9, 1, 1), b: none, exp: make_expect(17, 9, 0)};
    rows[8] = '{a: make_rect(3, 15, 9, 1), b: none, exp: make_expect(3, 15, 16)};
    rows[9] = '{a: make_rect(20, 2, 1, 7), b: none, exp: make_expect(20, 2, 12)};
    rows[10] = '{a: make_rect(12, 10, 4, 4), b: make_rect(3, 12, 5, 3),
                 exp: make_expect(12, 10, 12)};
    rows[11] = '{a: make_rect(20, 5, 3, 3), b: make_rect(2, 5, 2, 2),
                 exp: make_expect(2, 5, 4)};
    rows[12] = '{a: make_rect(0, 0, 32, 24), b: none, exp: make_expect(0, 0, 108)};
    rows[13] = '{a: make_rect(31, 23, 1, 1), b: none, exp: make_expect(31, 23, 0)};
    rows[14] = '{a: make_rect(31, 3, 1, 5), b: none, exp: make_expect(31, 3, 8)};
    rows[15] = '{a: make_rect(10, 23, 12, 1), b: none, exp: make_expect(10, 23, 22)};
  endtask

  task fill_rect(input rect_t r);
    for (int y = r.y; y < r.y + r.h; y++) begin
      for (int x = r.x; x < r.x + r.w; x++) begin
        mask[y * `FRAME_WIDTH + x] = 1'b1;
      end
    end
  endtask

  task load_mask(input test_row_t row);
    foreach (mask[i]) mask[i] = 1'b0;
    fill_rect(row.a);
    fill_rect(row.b);
  endtask

  task start_trace;
    start_valid = 1'b1;
    while (!start_ready) @(negedge clk_in);
    @(negedge clk_in);  // handshake took place on the edge between
    start_valid = 1'b0;
  endtask

  task accept_result(input int unsigned stall);
    while (!result_valid) @(negedge clk_in);
    repeat (stall) @(negedge clk_in);
    result_ready = 1'b1;
    @(negedge clk_in);
    result_ready = 1'b0;
  endtask

  task print_counts;
    $display("closing count: %0d errors, %0d of %0d results accepted",
             error_count, result_count, NUM_TESTS);
  endtask

  initial begin
    clk_in = 1'b0;
    rst_in = 1'b1;
    start_valid = 1'b0;
    result_ready = 1'b0;
    rd_pix = '0;
    rd_search_pix = 1'b0;
    exp_result = '0;
    foreach (mask[i]) mask[i] = 1'b0;
    for (int i = 0; i < LAT; i++) begin
      pix_pipe[i] = '0;
      search_pipe[i] = 1'b0;
    end
    void'($urandom(32'h4548));
    fill_table();
    cycle_limit = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      stall_len[t] = $urandom % 9;
      cycle_limit += PIXELS + LAT + rows[t].exp.perimeter * (LAT + 1) + stall_len[t];
    end
    cycle_limit = cycle_limit * 2;
    repeat (5) @(negedge clk_in);
    rst_in = 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      load_mask(rows[t]);
      exp_result = rows[t].exp;
      start_trace();
      accept_result(stall_len[t]);
    end
    repeat (4) @(negedge clk_in);
    print_counts();
    if (error_count == 0 && result_count == NUM_TESTS) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    wait (timed_out === 1'b1);
    print_counts();
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* contour_tracer.f */
+incdir+common
common/ccl_pkg.sv
verilog/raster_search.sv
verilog/trace_ctrl.sv
trace/neighbor_fetch.sv
trace/moore_step.sv
verilog/contour_tracer.sv
tests/trace_checker.sv
tests/contour_tracer_tb.sv
